//--- stage_cpu_pkg.sv
/*
 * Shared definitions for the multicycle core: widths, instruction
 * field positions, opcode, ALU and condition encodings, stage list
 */
package stage_cpu_pkg;

  // -------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------
  localparam int data_w     = 32;
  localparam int pc_w       = 25;
  localparam int addr_w     = 26;
  localparam int reg_addr_w = 4;
  localparam int imm_w      = 16;

  // Instruction fields
  localparam int op_msb    = 31;
  localparam int op_lsb    = 26;
  localparam int cond_msb  = 25;  // Also base / source register
  localparam int cond_lsb  = 22;
  localparam int set_bit   = 21;  // Flag update
  localparam int fld_a_msb = 20;
  localparam int fld_b_msb = 16;
  localparam int fld_c_msb = 12;
  localparam int aluop_msb = 8;

  // -------------------------------------------------------------------
  // Encodings
  // -------------------------------------------------------------------
  typedef enum logic [5:0] {
    op_noop  = 6'b00_0000,
    op_b     = 6'b00_0001,
    op_ldw   = 6'b00_0010,
    op_alu   = 6'b00_0011,
    op_stw   = 6'b00_0110,
    op_addil = 6'b00_1010,
    op_addih = 6'b00_1110,
    op_oril  = 6'b01_0010,
    op_orih  = 6'b01_0110,
    op_andil = 6'b01_1010,
    op_andih = 6'b01_1110
  } opcode_e;

  // Codes 1 and 9 (shift, multiply) are not implemented
  typedef enum logic [4:0] {
    alu_sub = 5'b00000,
    alu_add = 5'b00010,
    alu_xor = 5'b00100,
    alu_or  = 5'b00101,
    alu_and = 5'b00110
  } alu_op_e;

  typedef enum logic [3:0] {
    cond_eq, cond_ne, cond_hs, cond_lo,
    cond_mi, cond_pl, cond_vs, cond_vc,
    cond_hi, cond_ls, cond_ge, cond_lt,
    cond_gt, cond_le, cond_al, cond_nv
  } cond_e;

  typedef enum logic [2:0] {
    fetch_req, fetch_wait, decode, execute, mem_req, mem_wait
  } stage_e;

  typedef enum logic {y_alu, y_mem} y_sel_e;  // Write-back source
  typedef enum logic {b_reg, b_imm} b_sel_e;  // Second ALU operand

endpackage

//--- cpu_ctrl_if.sv
/*
 * Decode and control bundle between the sequencer and the datapath
 */
interface cpu_ctrl_if;
  import stage_cpu_pkg::*;

  logic [data_w-1:0]     ir;
  logic                  cond_pass;   // Latched in decode
  logic                  cond_load;
  logic                  ir_load;
  logic                  pc_load;
  logic                  branch_taken;
  logic                  flag_write;
  alu_op_e               alu_op;
  b_sel_e                b_sel;
  y_sel_e                y_sel;
  logic                  ma_from_pc;
  logic [data_w-1:0]     immediate;   // Already extended
  logic [reg_addr_w-1:0] addr_a;
  logic [reg_addr_w-1:0] addr_b;
  logic [reg_addr_w-1:0] addr_c;
  logic                  reg_write;

  modport seq (
    input  ir, cond_pass,
    output cond_load, ir_load, pc_load, branch_taken, flag_write, alu_op, b_sel, y_sel,
    output ma_from_pc, immediate, addr_a, addr_b, addr_c, reg_write
  );

  modport dp (
    output ir, cond_pass,
    input  cond_load, ir_load, pc_load, branch_taken, flag_write, alu_op, b_sel, y_sel,
    input  ma_from_pc, immediate, addr_a, addr_b, addr_c, reg_write
  );
endinterface

//--- reg_file.sv
/*
 * Working registers r1..r15 with two read ports and one write port.
 * r0 reads zero and discards writes
 */
module reg_file (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [stage_cpu_pkg::reg_addr_w-1:0] addr_a,
  input  logic [stage_cpu_pkg::reg_addr_w-1:0] addr_b,
  input  logic [stage_cpu_pkg::reg_addr_w-1:0] addr_c,
  input  logic                                 write,
  input  logic [stage_cpu_pkg::data_w-1:0]     write_data,
  output logic [stage_cpu_pkg::data_w-1:0]     data_a,
  output logic [stage_cpu_pkg::data_w-1:0]     data_b
);
  import stage_cpu_pkg::*;

  localparam int num_regs = 1 << reg_addr_w;

  logic [data_w-1:0] regs [1:num_regs-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write && addr_c != '0) begin
      regs[addr_c] <= write_data;
    end
  end

  assign data_a = (addr_a == '0) ? '0 : regs[addr_a];  // Zero register
  assign data_b = (addr_b == '0) ? '0 : regs[addr_b];

endmodule

//--- alu.sv
/*
 * Combinational ALU for add, subtract and the bitwise operations,
 * with N, Z, C and V derived from the result
 */
module alu (
  input  stage_cpu_pkg::alu_op_e               op,
  input  logic [stage_cpu_pkg::data_w-1:0]     in_a,
  input  logic [stage_cpu_pkg::data_w-1:0]     in_b,
  output logic [stage_cpu_pkg::data_w-1:0]     result,
  output logic                                 n,
  output logic                                 z,
  output logic                                 c,
  output logic                                 v
);
  import stage_cpu_pkg::*;

  localparam int msb = data_w - 1;

  logic [data_w:0] sum;  // Extra bit holds carry / borrow

  always_comb begin
    case (op)
      alu_add: sum = {1'b0, in_a} + {1'b0, in_b};
      alu_sub: sum = {1'b0, in_a} - {1'b0, in_b};
      alu_and: sum = {1'b0, in_a & in_b};
      alu_or:  sum = {1'b0, in_a | in_b};
      alu_xor: sum = {1'b0, in_a ^ in_b};
      default: sum = '0;  // Unimplemented codes
    endcase
  end

  assign result = sum[msb:0];
  assign n      = result[msb];
  assign z      = (result == '0);

  // Carry and overflow only meaningful for add and subtract
  always_comb begin
    c = 1'b0;
    v = 1'b0;
    case (op)
      alu_add: begin
        c = sum[data_w];
        v = (in_a[msb] & in_b[msb] & ~result[msb]) | (~in_a[msb] & ~in_b[msb] & result[msb]);
      end
      alu_sub: begin
        c = ~sum[data_w];  // No borrow
        v = (in_a[msb] & ~in_b[msb] & ~result[msb]) | (~in_a[msb] & in_b[msb] & result[msb]);
      end
      default: ;
    endcase
  end

endmodule

//--- flag_unit.sv
/*
 * Status flags N, Z, C, V and the condition check.
 * The condition result is latched once per instruction
 */
module flag_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flag_write,
  input  logic                  cond_load,
  input  logic                  n_in,
  input  logic                  z_in,
  input  logic                  c_in,
  input  logic                  v_in,
  input  stage_cpu_pkg::cond_e  cond,
  output logic                  cond_pass
);
  import stage_cpu_pkg::*;

  logic n, z, c, v;
  logic pass;

  always_ff @(posedge clk) begin
    if (reset) begin
      n <= 1'b0;
      z <= 1'b0;
      c <= 1'b0;
      v <= 1'b0;
      cond_pass <= 1'b0;
    end else begin
      if (flag_write) begin
        n <= n_in;
        z <= z_in;
        c <= c_in;
        v <= v_in;
      end
      if (cond_load) cond_pass <= pass;  // Flags as seen in decode
    end
  end

  // Condition evaluation on held flags
  always_comb begin
    pass = 1'b0;
    case (cond)
      cond_eq: pass = z;
      cond_ne: pass = ~z;
      cond_hs: pass = c;
      cond_lo: pass = ~c;
      cond_mi: pass = n;
      cond_pl: pass = ~n;
      cond_vs: pass = v;
      cond_vc: pass = ~v;
      cond_hi: pass = c & ~z;
      cond_ls: pass = ~c | z;
      cond_ge: pass = (n == v);
      cond_lt: pass = (n != v);
      cond_gt: pass = ~z & (n == v);
      cond_le: pass = z | (n != v);
      cond_al: pass = 1'b1;
      cond_nv: pass = 1'b0;
    endcase
  end

endmodule

//--- datapath.sv
/*
 * Core datapath: PC, instruction register, operand and result
 * registers, operand and write-back selects, memory address select
 */
module datapath (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [stage_cpu_pkg::data_w-1:0] memory_data_read,
  output logic [stage_cpu_pkg::addr_w-1:0] memory_addr,
  output logic [stage_cpu_pkg::data_w-1:0] memory_data_write,
  cpu_ctrl_if.dp                           ctrl
);
  import stage_cpu_pkg::*;

  logic [pc_w-1:0]   pc;
  logic [pc_w-1:0]   pc_step;
  logic [data_w-1:0] ir;
  logic [data_w-1:0] ra;   // Operand A
  logic [data_w-1:0] rb;   // Operand B
  logic [data_w-1:0] rm;   // Store data
  logic [data_w-1:0] rz;   // ALU result, also load/store address
  logic [data_w-1:0] ry;   // Write-back value
  logic [data_w-1:0] reg_a;
  logic [data_w-1:0] reg_b;
  logic [data_w-1:0] alu_in_b;
  logic [data_w-1:0] alu_result;
  logic [data_w-1:0] y_mux;
  logic              alu_n, alu_z, alu_c, alu_v;

  // -------------------------------------------------------------------
  // Program counter and instruction register
  // -------------------------------------------------------------------
  // Branch offset is relative to the branch's own address
  assign pc_step = ctrl.branch_taken ? ctrl.immediate[pc_w-1:0] : {{(pc_w-1){1'b0}}, 1'b1};

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      ir <= '0;
    end else begin
      if (ctrl.pc_load) pc <= pc + pc_step;
      if (ctrl.ir_load) ir <= memory_data_read;
    end
  end

  assign ctrl.ir = ir;

  // -------------------------------------------------------------------
  // Intermediate registers
  // -------------------------------------------------------------------
  always_ff @(posedge clk) begin
    ra <= reg_a;
    rb <= reg_b;
    rm <= rb;
    rz <= alu_result;
    ry <= y_mux;
  end

  assign alu_in_b = (ctrl.b_sel == b_imm) ? ctrl.immediate : rb;
  assign y_mux    = (ctrl.y_sel == y_mem) ? memory_data_read : alu_result;

  // Fetch from PC, data access from rz
  assign memory_addr = ctrl.ma_from_pc ? {{(addr_w-pc_w){1'b0}}, pc} : rz[addr_w-1:0];
  assign memory_data_write = rm;

  reg_file reg_file_i (
    .clk        (clk),
    .reset      (reset),
    .addr_a     (ctrl.addr_a),
    .addr_b     (ctrl.addr_b),
    .addr_c     (ctrl.addr_c),
    .write      (ctrl.reg_write),
    .write_data (ry),
    .data_a     (reg_a),
    .data_b     (reg_b)
  );

  alu alu_i (
    .op     (ctrl.alu_op),
    .in_a   (ra),
    .in_b   (alu_in_b),
    .result (alu_result),
    .n      (alu_n),
    .z      (alu_z),
    .c      (alu_c),
    .v      (alu_v)
  );

  flag_unit flag_unit_i (
    .clk        (clk),
    .reset      (reset),
    .flag_write (ctrl.flag_write),
    .cond_load  (ctrl.cond_load),
    .n_in       (alu_n),
    .z_in       (alu_z),
    .c_in       (alu_c),
    .v_in       (alu_v),
    .cond       (cond_e'(ir[cond_msb:cond_lsb])),
    .cond_pass  (ctrl.cond_pass)
  );

endmodule

//--- sequencer.sv
/*
 * Stage sequencer. Steps each instruction through fetch, decode,
 * execute and the optional memory stages, and decodes the
 * instruction into register numbers, immediate and control strobes
 */
module sequencer (
  input  logic   clk,
  input  logic   reset,
  input  logic   memory_busy,
  output logic   memory_read_req,
  output logic   memory_write_req,
  cpu_ctrl_if.seq ctrl
);
  import stage_cpu_pkg::*;

  stage_e                stage;
  stage_e                stage_next;
  opcode_e               opcode;
  logic [imm_w-1:0]      imm;
  logic [reg_addr_w-1:0] fld_cond;
  logic [reg_addr_w-1:0] fld_a;
  logic [reg_addr_w-1:0] fld_b;
  logic [reg_addr_w-1:0] fld_c;
  logic                  writes_back;   // Instruction has a register result
  logic                  is_mem;

  assign opcode   = opcode_e'(ctrl.ir[op_msb:op_lsb]);
  assign imm      = ctrl.ir[imm_w-1:0];
  assign fld_cond = ctrl.ir[cond_msb:cond_lsb];
  assign fld_a    = ctrl.ir[fld_a_msb -: reg_addr_w];
  assign fld_b    = ctrl.ir[fld_b_msb -: reg_addr_w];
  assign fld_c    = ctrl.ir[fld_c_msb -: reg_addr_w];
  assign is_mem   = (opcode == op_ldw) || (opcode == op_stw);

  // -------------------------------------------------------------------
  // Stage register
  // -------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) stage <= fetch_req;
    else stage <= stage_next;
  end

  always_comb begin
    stage_next = stage;
    case (stage)
      fetch_req:  stage_next = fetch_wait;
      fetch_wait: if (!memory_busy) stage_next = decode;  // Hold while busy
      decode:     stage_next = execute;
      execute:    stage_next = is_mem ? mem_req : fetch_req;
      mem_req:    stage_next = mem_wait;
      mem_wait:   if (!memory_busy) stage_next = fetch_req;
      default:    stage_next = fetch_req;
    endcase
  end

  // -------------------------------------------------------------------
  // Instruction decode
  // -------------------------------------------------------------------
  always_comb begin
    ctrl.addr_a    = '0;
    ctrl.addr_b    = '0;
    ctrl.addr_c    = fld_a;
    ctrl.immediate = {{(data_w-imm_w){imm[imm_w-1]}}, imm};  // Sign extended
    ctrl.alu_op    = alu_add;
    ctrl.b_sel     = b_imm;
    writes_back    = 1'b0;
    case (opcode)
      op_noop: writes_back = 1'b0;
      op_alu: begin
        ctrl.addr_a = fld_a;
        ctrl.addr_b = fld_b;
        ctrl.addr_c = fld_c;
        ctrl.alu_op = alu_op_e'(ctrl.ir[aluop_msb -: $bits(alu_op_e)]);
        ctrl.b_sel  = b_reg;
        writes_back = 1'b1;
      end
      op_b: ;  // Offset only
      op_ldw: begin
        ctrl.addr_a = fld_cond;
        writes_back = 1'b1;
      end
      op_stw: begin
        ctrl.addr_a = fld_cond;
        ctrl.addr_b = fld_a;  // Store data
      end
      op_addil: begin
        ctrl.addr_a = fld_cond;
        writes_back = 1'b1;
      end
      op_addih, op_orih: begin
        ctrl.addr_a    = fld_cond;
        ctrl.immediate = {imm, {(data_w-imm_w){1'b0}}};
        ctrl.alu_op    = (opcode == op_orih) ? alu_or : alu_add;
        writes_back    = 1'b1;
      end
      op_oril: begin
        ctrl.addr_a    = fld_cond;
        ctrl.immediate = {{(data_w-imm_w){1'b0}}, imm};
        ctrl.alu_op    = alu_or;
        writes_back    = 1'b1;
      end
      op_andil: begin
        ctrl.addr_a    = fld_cond;
        ctrl.immediate = {{(data_w-imm_w){1'b1}}, imm};  // Keeps upper half
        ctrl.alu_op    = alu_and;
        writes_back    = 1'b1;
      end
      op_andih: begin
        ctrl.addr_a    = fld_cond;
        ctrl.immediate = {imm, {(data_w-imm_w){1'b1}}};
        ctrl.alu_op    = alu_and;
        writes_back    = 1'b1;
      end
      default: ;
    endcase
  end

  // -------------------------------------------------------------------
  // Per-stage strobes
  // -------------------------------------------------------------------
  always_comb begin
    memory_read_req   = 1'b0;
    memory_write_req  = 1'b0;
    ctrl.ir_load      = 1'b0;
    ctrl.pc_load      = 1'b0;
    ctrl.branch_taken = 1'b0;
    ctrl.flag_write   = 1'b0;
    ctrl.cond_load    = 1'b0;
    ctrl.reg_write    = 1'b0;
    ctrl.ma_from_pc   = 1'b0;
    ctrl.y_sel        = y_alu;
    case (stage)
      fetch_req: begin
        // Write-back of the previous instruction overlaps the fetch
        ctrl.ma_from_pc = 1'b1;
        memory_read_req = 1'b1;
        ctrl.reg_write  = writes_back && (ctrl.cond_pass || opcode != op_alu);
      end
      fetch_wait: ctrl.ir_load = !memory_busy;
      decode:     ctrl.cond_load = 1'b1;
      execute: begin
        ctrl.pc_load      = 1'b1;
        ctrl.branch_taken = (opcode == op_b) && ctrl.cond_pass;
        ctrl.flag_write   = (opcode == op_alu) && ctrl.ir[set_bit];  // Unconditional
      end
      mem_req: begin
        memory_read_req  = (opcode == op_ldw);
        memory_write_req = (opcode == op_stw);
      end
      mem_wait: ctrl.y_sel = y_mem;  // Captures load data on the last cycle
      default: ;
    endcase
    if (reset) begin
      memory_read_req  = 1'b0;  // Requests held off while reset is high
      memory_write_req = 1'b0;
    end
  end

endmodule

//--- stage_cpu.sv
/*
 * Multicycle core top level. Joins the sequencer and the datapath
 * and exposes the word-addressed memory bus
 */
module stage_cpu (
  input  logic                             clk,
  input  logic                             reset,
  output logic                             memory_read_req,
  output logic                             memory_write_req,
  output logic [stage_cpu_pkg::addr_w-1:0] memory_addr,
  output logic [stage_cpu_pkg::data_w-1:0] memory_data_write,
  input  logic [stage_cpu_pkg::data_w-1:0] memory_data_read,
  input  logic                             memory_busy
);

  cpu_ctrl_if ctrl ();

  sequencer sequencer_i (
    .clk              (clk),
    .reset            (reset),
    .memory_busy      (memory_busy),
    .memory_read_req  (memory_read_req),
    .memory_write_req (memory_write_req),
    .ctrl             (ctrl.seq)
  );

  datapath datapath_i (
    .clk               (clk),
    .reset             (reset),
    .memory_data_read  (memory_data_read),
    .memory_addr       (memory_addr),
    .memory_data_write (memory_data_write),
    .ctrl              (ctrl.dp)
  );

endmodule

//--- stage_cpu_props.sv
/*
 * Memory strobe checks for the multicycle core, bound to the top level
 */
module stage_cpu_props (
  input logic clk,
  input logic reset,
  input logic memory_read_req,
  input logic memory_write_req
);

  // Read and write never requested together
  a_one_request : assert property (@(posedge clk) !(memory_read_req && memory_write_req))
    else $error("Read and write requests are high in the same cycle");

  a_read_pulse : assert property (@(posedge clk) disable iff (reset)
    memory_read_req |=> !memory_read_req)
    else $error("Read request lasted more than one cycle");

  a_write_pulse : assert property (@(posedge clk) disable iff (reset)
    memory_write_req |=> !memory_write_req)
    else $error("Write request lasted more than one cycle");

  // Bus stays quiet while reset is high
  a_reset_quiet : assert property (@(posedge clk)
    reset |-> !memory_read_req && !memory_write_req)
    else $error("Memory request seen during reset");

endmodule

bind stage_cpu stage_cpu_props stage_cpu_props_i (
  .clk              (clk),
  .reset            (reset),
  .memory_read_req  (memory_read_req),
  .memory_write_req (memory_write_req)
);

//--- stage_cpu_tb.sv
/*
 * Directed testbench for the multicycle core: memory model with
 * random wait states, program loader, store checks and watchdog
 */
module stage_cpu_tb;
  import stage_cpu_pkg::*;

  localparam int mem_words   = 1024;
  localparam int done_addr   = 1000;  // Final store marks the end of a program
  localparam int total_instr = 400;
  localparam int timeout     = total_instr * 12 * 100 + 100000;

  logic              clk = 1'b0;
  logic              reset;
  logic              memory_read_req;
  logic              memory_write_req;
  logic [addr_w-1:0] memory_addr;
  logic [data_w-1:0] memory_data_write;
  logic [data_w-1:0] memory_data_read;
  logic              memory_busy;

  logic [data_w-1:0] mem [0:mem_words-1];
  logic [addr_w-1:0] lat_addr = '0;
  logic [addr_w-1:0] first_read_addr;
  logic [addr_w-1:0] st_addr [$];
  logic [data_w-1:0] st_data [$];
  logic [addr_w-1:0] exp_addr [$];
  logic [data_w-1:0] exp_data [$];
  logic [31:0]       seed = 32'hae43_a89a;
  int                wait_cnt = 0;
  int                prog_pc;
  int                error_count = 0;
  bit                waits_on = 0;
  bit                done;
  bit                first_read_seen;
  bit                prev_read = 0;
  bit                prev_write = 0;

  stage_cpu stage_cpu_i (.*);

  always #50 clk = ~clk;

  initial begin
    #(timeout);
    $display("Watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // ---------------------------------------------------------------------
  // Memory model
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    // Strobe rules of the bus
    if (memory_read_req && memory_write_req) begin
      $display("Read and write requests were raised in the same cycle at time %0t", $time);
      error_count++;
    end
    if ((prev_read && memory_read_req) || (prev_write && memory_write_req)) begin
      $display("A memory request lasted more than one cycle at time %0t", $time);
      error_count++;
    end
    prev_read  = memory_read_req;
    prev_write = memory_write_req;
    if (reset) begin
      if (memory_read_req || memory_write_req) begin
        $display("A memory request was raised during reset at time %0t", $time);
        error_count++;
      end
      wait_cnt = 0;
    end else if (memory_read_req || memory_write_req) begin
      lat_addr = memory_addr;
      if (memory_addr >= mem_words) begin
        $display("Access outside the memory at address %h, time %0t", memory_addr, $time);
        error_count++;
      end else if (memory_write_req) begin
        mem[memory_addr] = memory_data_write;
        if (memory_addr == done_addr) done = 1;
        else begin
          st_addr.push_back(memory_addr);
          st_data.push_back(memory_data_write);
        end
      end else if (!first_read_seen) begin
        first_read_seen = 1;
        first_read_addr = memory_addr;
      end
      wait_cnt = waits_on ? (next_rand() >> 16) % 4 : 0;
    end else if (wait_cnt > 0) begin
      wait_cnt--;
    end
    #10;
    memory_busy      = (wait_cnt > 0);
    memory_data_read = mem[lat_addr[9:0]];
  end

  // ---------------------------------------------------------------------
  // Instruction encoders and program loader
  // ---------------------------------------------------------------------
  function automatic logic [31:0] enc_alu(alu_op_e op, cond_e cc, logic set,
                                          logic [3:0] a, logic [3:0] b, logic [3:0] c);
    return {op_alu, cc, set, a, b, c, op, 4'b0};
  endfunction

  function automatic logic [31:0] enc_imm(opcode_e opc, logic [3:0] dst, logic [3:0] src,
                                          logic [15:0] imm);
    return {opc, src, 1'b0, dst, 1'b0, imm};
  endfunction

  function automatic logic [31:0] enc_branch(cond_e cc, logic [15:0] off);
    return {op_b, cc, 6'b0, off};
  endfunction

  function automatic logic [31:0] sext16(logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  function automatic bit cond_holds(cond_e cc, logic [3:0] f);  // f = {n, z, c, v}
    case (cc)
      cond_eq: return f[2];
      cond_ne: return !f[2];
      cond_hs: return f[1];
      cond_lo: return !f[1];
      cond_mi: return f[3];
      cond_pl: return !f[3];
      cond_vs: return f[0];
      cond_vc: return !f[0];
      cond_hi: return f[1] && !f[2];
      cond_ls: return !f[1] || f[2];
      cond_ge: return f[3] == f[0];
      cond_lt: return f[3] != f[0];
      cond_gt: return !f[2] && (f[3] == f[0]);
      cond_le: return f[2] || (f[3] != f[0]);
      cond_al: return 1;
      default: return 0;
    endcase
  endfunction

  task automatic emit(logic [31:0] word);
    mem[prog_pc] = word;
    prog_pc++;
  endtask

  task automatic imm_op(opcode_e opc, logic [3:0] dst, logic [3:0] src, logic [15:0] imm);
    emit(enc_imm(opc, dst, src, imm));
  endtask

  task automatic expect_store(int addr, logic [data_w-1:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // ---------------------------------------------------------------------
  // Compare tasks
  // ---------------------------------------------------------------------
  task automatic check_data(string name, logic [data_w-1:0] exp, logic [data_w-1:0] act);
    if (act !== exp) begin
      $display("Fail time=%0t %s expected %h got %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_addr(string name, logic [addr_w-1:0] exp, logic [addr_w-1:0] act);
    if (act !== exp) begin
      $display("Fail time=%0t %s expected %h got %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      $display("Fail time=%0t %s expected %0d got %0d", $time, name, exp, act);
      error_count++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Test sequencing
  // ---------------------------------------------------------------------
  task automatic begin_test();
    @(posedge clk);
    #10;
    reset    = 1'b1;
    waits_on = 0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ i;
    end
    st_addr.delete();
    st_data.delete();
    exp_addr.delete();
    exp_data.delete();
    prog_pc         = 0;
    done            = 0;
    first_read_seen = 0;
    repeat (2) @(posedge clk);
    #10;
  endtask

  // Ends the program, releases reset and compares the stores
  task automatic run_program(string test_name);
    int n;
    n = 0;
    imm_op(op_stw, 4'd0, 4'd0, done_addr);
    emit(enc_branch(cond_al, 16'd0));  // Halt loop
    reset = 1'b0;
    while (!done && n < prog_pc * 12 + 50) begin
      @(posedge clk);
      n++;
    end
    if (!done) begin
      $display("Test %s did not reach its final store", test_name);
      error_count++;
    end
    check_count({test_name, " store count"}, exp_addr.size(), st_addr.size());
    for (int i = 0; i < exp_addr.size() && i < st_addr.size(); i++) begin
      check_addr($sformatf("%s store %0d address", test_name, i), exp_addr[i], st_addr[i]);
      check_data($sformatf("%s store %0d data", test_name, i), exp_data[i], st_data[i]);
    end
  endtask

  task automatic test_reset();
    begin_test();
    imm_op(op_addil, 4'd1, 4'd0, 16'd5);
    imm_op(op_stw, 4'd1, 4'd0, 16'd600);
    imm_op(op_stw, 4'd1, 4'd0, 16'd601);
    expect_store(600, 5);
    expect_store(601, 5);
    run_program("reset");
    check_addr("first fetch address", '0, first_read_addr);
  endtask

  task automatic test_immediates();
    begin_test();
    imm_op(op_addil, 4'd1, 4'd0, 16'h8001);
    imm_op(op_addih, 4'd2, 4'd0, 16'h1234);
    imm_op(op_oril,  4'd3, 4'd0, 16'h8001);
    imm_op(op_orih,  4'd4, 4'd0, 16'habcd);
    imm_op(op_addil, 4'd6, 4'd0, 16'hffff);
    imm_op(op_andil, 4'd7, 4'd6, 16'h00f0);
    imm_op(op_andih, 4'd8, 4'd6, 16'h0f00);
    for (int r = 1; r <= 8; r++) begin
      imm_op(op_stw, r, 4'd0, 600 + r);
    end
    expect_store(601, sext16(16'h8001));
    expect_store(602, {16'h1234, 16'h0000});
    expect_store(603, {16'h0000, 16'h8001});
    expect_store(604, {16'habcd, 16'h0000});
    expect_store(605, 0);
    expect_store(606, sext16(16'hffff));
    expect_store(607, {16'hffff, 16'h00f0});
    expect_store(608, {16'h0f00, 16'hffff});
    run_program("immediates");
  endtask

  task automatic test_alu_ops();
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    a = 32'h7000_0005;
    b = sext16(16'hfffd);
    begin_test();
    imm_op(op_addih, 4'd1, 4'd0, 16'h7000);
    imm_op(op_oril,  4'd1, 4'd1, 16'h0005);
    imm_op(op_addil, 4'd2, 4'd0, 16'hfffd);
    emit(enc_alu(alu_add, cond_al, 0, 4'd1, 4'd2, 4'd3));
    emit(enc_alu(alu_sub, cond_al, 0, 4'd1, 4'd2, 4'd4));
    emit(enc_alu(alu_and, cond_al, 0, 4'd1, 4'd2, 4'd5));
    emit(enc_alu(alu_or,  cond_al, 0, 4'd1, 4'd2, 4'd6));
    emit(enc_alu(alu_xor, cond_al, 0, 4'd1, 4'd2, 4'd7));
    emit(enc_alu(alu_add, cond_al, 0, 4'd1, 4'd2, 4'd0));  // r0 write dropped
    emit(enc_alu(alu_add, cond_al, 0, 4'd0, 4'd2, 4'd8));
    for (int r = 0; r <= 8; r++) begin
      imm_op(op_stw, r, 4'd0, 610 + r);
    end
    expect_store(610, 0);
    expect_store(611, a);
    expect_store(612, b);
    expect_store(613, a + b);
    expect_store(614, a - b);
    expect_store(615, a & b);
    expect_store(616, a | b);
    expect_store(617, a ^ b);
    expect_store(618, b);
    run_program("alu");
  endtask

  task automatic test_loads();
    begin_test();
    waits_on = 1;
    imm_op(op_ldw,   4'd1, 4'd0, 16'd700);
    imm_op(op_ldw,   4'd2, 4'd0, 16'd701);
    imm_op(op_addil, 4'd3, 4'd0, 16'd702);
    imm_op(op_ldw,   4'd4, 4'd3, 16'd1);
    imm_op(op_ldw,   4'd5, 4'd3, 16'hfffe);  // Negative offset
    imm_op(op_stw, 4'd1, 4'd0, 16'd800);
    imm_op(op_stw, 4'd2, 4'd0, 16'd801);
    imm_op(op_stw, 4'd4, 4'd0, 16'd802);
    imm_op(op_stw, 4'd5, 4'd0, 16'd803);
    expect_store(800, mem[700]);
    expect_store(801, mem[701]);
    expect_store(802, mem[703]);
    expect_store(803, mem[700]);
    run_program("loads");
    waits_on = 0;
  endtask

  task automatic test_branches();
    logic [3:0] pa [5] = '{4'd1, 4'd2, 4'd1, 4'd3, 4'd5};
    logic [3:0] pb [5] = '{4'd1, 4'd1, 4'd2, 4'd4, 4'd6};
    logic [3:0] nzcv [5] = '{4'b0110, 4'b1000, 4'b0010, 4'b0011, 4'b1001};
    int idx;
    idx = 0;
    begin_test();
    imm_op(op_addil, 4'd1, 4'd0, 16'd5);
    imm_op(op_addil, 4'd2, 4'd0, 16'd3);
    imm_op(op_addih, 4'd3, 4'd0, 16'h8000);
    imm_op(op_addil, 4'd4, 4'd0, 16'd1);
    imm_op(op_addil, 4'd5, 4'd3, 16'hffff);  // 0x7fffffff
    imm_op(op_addil, 4'd6, 4'd0, 16'hffff);
    for (int p = 0; p < 5; p++) begin
      emit(enc_alu(alu_sub, cond_al, 1, pa[p], pb[p], 4'd0));
      for (int c = 0; c < 16; c++) begin
        emit(enc_branch(cond_e'(c), 16'd2));  // Skips the marker store
        imm_op(op_stw, 4'd1, 4'd0, 600 + idx);
        if (!cond_holds(cond_e'(c), nzcv[p])) expect_store(600 + idx, 5);
        idx++;
      end
    end
    run_program("branches");
  endtask

  task automatic test_cond_alu();
    begin_test();
    imm_op(op_addil, 4'd1, 4'd0, 16'd5);
    imm_op(op_addil, 4'd2, 4'd0, 16'd7);
    imm_op(op_addil, 4'd3, 4'd0, 16'd100);
    imm_op(op_addil, 4'd4, 4'd0, 16'd200);
    emit(enc_alu(alu_sub, cond_al, 1, 4'd1, 4'd1, 4'd0));  // Z set
    emit(enc_alu(alu_add, cond_ne, 0, 4'd1, 4'd2, 4'd3));
    emit(enc_alu(alu_add, cond_eq, 0, 4'd1, 4'd2, 4'd4));
    imm_op(op_stw, 4'd3, 4'd0, 16'd650);
    imm_op(op_stw, 4'd4, 4'd0, 16'd651);
    expect_store(650, 100);
    expect_store(651, 12);
    run_program("conditional alu");
  endtask

  initial begin
    reset            = 1'b1;
    memory_busy      = 1'b0;
    memory_data_read = '0;
    test_reset();
    test_immediates();
    test_alu_ops();
    test_loads();
    test_branches();
    test_cond_alu();
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- stage_cpu.f
stage_cpu_pkg.sv
cpu_ctrl_if.sv
reg_file.sv
alu.sv
flag_unit.sv
datapath.sv
sequencer.sv
stage_cpu.sv
stage_cpu_props.sv
stage_cpu_tb.sv
